//--- Bender.yml
package:
  name: dds

export_include_dirs:
  - .

sources:
  - files:
      - dds_num_pkg.sv
      - dds_table_pkg.sv
      - delay_line.sv
      - phase_accumulator.sv
      - quadrant_fold.sv
      - cos_table.sv
      - cosine_interp.sv
      - dds_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - dds_assertions.sv
      - dds_tb.sv

//--- cos_table.sv
// read only; contents fixed at elaboration, so amplitude changes need a rebuild
`timescale 1ns/1ns
`include "dds_cfg.svh"

module cos_table (
   input logic c,
   input logic advance, // read register holds while stalled
   input dds_table_pkg::table_addr_t addr,
   output dds_table_pkg::table_word_t word
);
   import dds_table_pkg::*;

   localparam int entries = 1 << `DDS_TABLE_ABITS;

   table_word_t rom [entries];

   // one constant per entry, evaluated at elaboration
   for (genvar i = 0; i < entries; i++) begin : g_rom
      localparam table_word_t entry_value = table_entry(table_addr_t'(i));
      assign rom[i] = entry_value;
   end

   // last entry's slope equals its coarse value, so interpolation
   // runs down to zero at the quarter point

   always_ff @(posedge c) begin
      if (advance) begin
         word <= rom[addr]; // registered read, one advance of latency
      end
   end

endmodule

//--- cosine_interp.sv
// word must arrive one advance after frac and sign; the consumer must keep ready stable per cycle
`timescale 1ns/1ns
`include "dds_cfg.svh"

module cosine_interp (
   input logic c,
   input logic reset,
   input dds_num_pkg::frac_t frac,
   input logic sign,
   input logic fold_valid,
   input dds_table_pkg::table_word_t word,
   output dds_num_pkg::sample_t sample,
   output logic sample_valid,
   input logic sample_ready,
   output logic advance
);
   import dds_num_pkg::*;

   localparam int coarse_w = `DDS_SAMPLE_W - 1;
   localparam int slope_w = `DDS_SLOPE_W;
   localparam int frac_w = `DDS_FRAC_W;

   frac_t frac_d;                     // lines up with word
   logic sign_d;                      // lines up with the sign stage
   logic [slope_w+frac_w-1:0] prod;   // slope*frac, full width
   logic [coarse_w-1:0] coarse_d;     // coarse held beside prod
   logic [coarse_w-1:0] mag;          // interpolated magnitude
   sample_t mag_s;

   // stall the whole pipe only when a sample is waiting and not taken
   assign advance = sample_ready || !sample_valid;

   delay_line #(.payload_t(frac_t), .DEPTH(1)) u_frac_delay (
      .c(c),
      .reset(reset),
      .advance(advance),
      .d(frac),
      .q(frac_d)
   );

   delay_line #(.payload_t(logic), .DEPTH(3)) u_sign_delay (
      .c(c),
      .reset(reset),
      .advance(advance),
      .d(sign),
      .q(sign_d)
   );

   // table, multiply, subtract, sign
   delay_line #(.payload_t(logic), .DEPTH(`DDS_LATENCY - 2)) u_valid_delay (
      .c(c),
      .reset(reset),
      .advance(advance),
      .d(fold_valid),
      .q(sample_valid)
   );

   assign mag_s = sample_t'({1'b0, mag}); // positive, top bit clear

   always_ff @(posedge c) begin
      if (advance) begin
         prod <= word.slope * frac_d; // 8x10 fits in 18 bits
         coarse_d <= word.coarse;
         // drop below coarse by the fraction of one step; never underflows
         mag <= coarse_d - {{(coarse_w-slope_w){1'b0}}, prod[slope_w+frac_w-1:frac_w]};
         sample <= sign_d ? -mag_s : mag_s;
      end
   end

endmodule

//--- dds_assertions.sv
// checks only the output handshake of dds_top; needs reset asserted at time 0 so valid is known
`timescale 1ns/1ns

module dds_assertions (
   input logic c,
   input logic reset,
   input dds_num_pkg::sample_t sample,
   input logic sample_valid,
   input logic sample_ready
);

   int assert_failures = 0; // read by the testbench at the end

   // valid is registered, so it clears one edge after reset is seen
   a_valid_low_in_reset : assert property (@(posedge c) reset |=> !sample_valid)
      else begin
         assert_failures++;
         $error("sample_valid high while reset was asserted");
      end

   // a stalled sample must not change under the consumer
   a_sample_holds : assert property (@(posedge c) disable iff (reset)
      sample_valid && !sample_ready |=> $stable(sample))
      else begin
         assert_failures++;
         $error("sample changed while stalled");
      end

   // offered sample stays offered until taken
   a_valid_holds : assert property (@(posedge c) disable iff (reset)
      sample_valid && !sample_ready |=> sample_valid)
      else begin
         assert_failures++;
         $error("sample_valid dropped without a transfer");
      end

endmodule

bind dds_top dds_assertions u_assert (
   .c(c),
   .reset(reset),
   .sample(sample),
   .sample_valid(sample_valid),
   .sample_ready(sample_ready)
);

//--- dds_cfg.svh
// widths are tied together: frac is phase minus 12 bits, table words must fit an 18 bit sample
`ifndef DDS_CFG_SVH
`define DDS_CFG_SVH

// phase word, wraps modulo 2^22
`define DDS_PHASE_W 22
`define DDS_SAMPLE_W 18 // signed output, two's complement

// quarter wave table, 1024 entries
`define DDS_TABLE_ABITS 10

// 2 quadrant bits + 10 address bits sit above the fraction
`define DDS_FRAC_W (`DDS_PHASE_W - 12)
`define DDS_SLOPE_W 8 // largest step near the quarter point is about 201

`define DDS_AMPLITUDE 131071 // full scale, fits the unsigned 17 bit coarse field
// accumulator, fold, table, then multiply, subtract and sign
`define DDS_LATENCY 6

`endif

//--- dds_num_pkg.sv
// numeric types only; widths come from dds_cfg.svh and are not meant to change at run time
`include "dds_cfg.svh"

package dds_num_pkg;

   // phase word, unsigned, wraps naturally
   typedef logic [`DDS_PHASE_W-1:0] phase_t;

   // low phase bits used for linear interpolation
   typedef logic [`DDS_FRAC_W-1:0] frac_t;

   // output sample, signed
   typedef logic signed [`DDS_SAMPLE_W-1:0] sample_t;

   // magnitude never exceeds DDS_AMPLITUDE so the sign bit is free
   // for the negation in the last stage

endpackage

//--- dds_table_pkg.sv
// table contents use real math, so table_entry is for elaboration only, not for run time logic
`include "dds_cfg.svh"

package dds_table_pkg;

   typedef logic [`DDS_TABLE_ABITS-1:0] table_addr_t;

   typedef struct packed {
      logic [`DDS_SAMPLE_W-2:0] coarse; // rounded cos at the entry, unsigned
      logic [`DDS_SLOPE_W-1:0] slope;   // this coarse minus the next one
   } table_word_t;

   // one quarter wave entry; entry n covers angle (pi/2)*n/1024
   function automatic table_word_t table_entry(input table_addr_t a);
      real step;
      int c_here;
      int c_next;
      int diff;
      table_word_t w;
      step = 3.14159265358979323846 / 2.0 / real'(1 << `DDS_TABLE_ABITS);
      c_here = int'(real'(`DDS_AMPLITUDE) * $cos(step * real'(a))); // int' rounds to nearest
      c_next = int'(real'(`DDS_AMPLITUDE) * $cos(step * (real'(a) + 1.0))); // 0 past the end
      diff = c_here - c_next;
      w.coarse = c_here[`DDS_SAMPLE_W-2:0];
      w.slope = diff[`DDS_SLOPE_W-1:0];
      return w;
   endfunction

endpackage

//--- dds_tb.sv
// directed tests of dds_top; freq and offset only change inside reset, tolerance is a few LSB
`timescale 1ns/1ns
`include "dds_cfg.svh"

module dds_tb;
   import dds_num_pkg::*;

   localparam int period_ns = 8;
   localparam real two_pi = 6.283185307179586;
   localparam int n_timing = 12;    // edges watched after reset
   localparam int n_quad = 16;      // four full turns at a quarter step
   localparam int n_random = 300;
   localparam int n_stall = 300;
   localparam int n_offset = 200;
   localparam int n_tests = 5;
   // each sample gets 4 cycles of budget, plus reset and some slack per test
   localparam int total_samples = n_timing + n_quad + n_random + n_stall + n_offset;
   localparam int watchdog_ns = total_samples * 4 * period_ns + n_tests * 12 * period_ns;

   logic c;
   logic reset;
   phase_t freq;
   phase_t offset;
   sample_t sample;
   logic sample_valid;
   logic sample_ready;

   sample_t got [$];        // accepted samples, in order of transfer
   int checks = 0;
   int errors = 0;
   int total_fail;

   tb_clock_gen #(.PERIOD_NS(period_ns)) u_clk (.c(c));

   dds_top UUT (
      .c(c),
      .reset(reset),
      .freq(freq),
      .offset(offset),
      .sample(sample),
      .sample_valid(sample_valid),
      .sample_ready(sample_ready)
   );

   // ideal cosine at a phase word, rounded to the nearest integer
   function automatic int model_sample(input phase_t p);
      real angle;
      angle = two_pi * real'(p) / real'(1 << `DDS_PHASE_W);
      return int'(real'(`DDS_AMPLITUDE) * $cos(angle));
   endfunction

   // settings are loaded while reset is high, ready starts high
   task automatic apply_reset(input phase_t f, input phase_t off);
      @(posedge c);
      reset <= 1'b1;
      freq <= f;
      offset <= off;
      sample_ready <= 1'b1;
      repeat (10) @(posedge c);
      reset <= 1'b0; // next edge is the first one out of reset
   endtask

   // ready is redrawn every edge, transfers are seen at the falling edge
   task automatic collect_samples(input int n, input int stall_pct);
      got.delete();
      while (got.size() < n) begin
         @(posedge c);
         if (stall_pct > 0 && ($urandom % 100) < stall_pct)
            sample_ready <= 1'b0;
         else
            sample_ready <= 1'b1;
         @(negedge c);
         if (sample_valid && sample_ready)
            got.push_back(sample); // moves on the coming rising edge
      end
      @(posedge c); // let the last transfer complete
   endtask

   // sample k must sit near the cosine of off + k*f
   task automatic compare_to_model(input phase_t f, input phase_t off, input int tol,
                                   input string label);
      phase_t p;
      int expected;
      int diff;
      p = off;
      foreach (got[k]) begin
         expected = model_sample(p);
         diff = int'(got[k]) - expected;
         checks++;
         if (diff > tol || diff < -tol) begin
            errors++;
            $display("mismatch sample[%0d] (%s): got 0x%h expected 0x%h",
                     k, label, got[k], sample_t'(expected));
         end
         p = p + f; // wraps mod 2^22
      end
   endtask

   // valid must stay low for the first five edges, then rise and stay
   task automatic check_valid_timing();
      logic want;
      apply_reset(phase_t'(22'h001000), '0);
      for (int edge_n = 1; edge_n <= n_timing; edge_n++) begin
         @(posedge c);
         @(negedge c);
         want = (edge_n >= `DDS_LATENCY);
         checks++;
         if (sample_valid !== want) begin
            errors++;
            $display("mismatch sample_valid after edge %0d: got 0x%h expected 0x%h",
                     edge_n, sample_valid, want);
         end
      end
   endtask

   // quarter turn steps hit each quadrant once per four samples
   task automatic check_quadrants();
      int pattern [4];
      int diff;
      pattern[0] = `DDS_AMPLITUDE;
      pattern[1] = 0;
      pattern[2] = -`DDS_AMPLITUDE;
      pattern[3] = 0;
      apply_reset(phase_t'(1 << 20), '0);
      collect_samples(n_quad, 0);
      foreach (got[k]) begin
         diff = int'(got[k]) - pattern[k % 4];
         checks++;
         if (diff > 1 || diff < -1) begin
            errors++;
            $display("mismatch sample[%0d] (quadrant %0d): got 0x%h expected 0x%h",
                     k, k % 4, got[k], sample_t'(pattern[k % 4]));
         end
      end
   endtask

   task automatic check_random_freq();
      phase_t f;
      f = phase_t'($urandom);
      if (f == '0)
         f = phase_t'(1); // a zero step would test nothing
      apply_reset(f, '0);
      collect_samples(n_random, 0);
      compare_to_model(f, '0, 3, "random freq");
   endtask

   // about 40% stalls, stream must still be gapless
   task automatic check_back_pressure();
      phase_t f;
      f = phase_t'($urandom) | phase_t'(1);
      apply_reset(f, '0);
      collect_samples(n_stall, 40);
      compare_to_model(f, '0, 3, "back-pressure");
   endtask

   // three quarter turns of offset turns the cosine into a sine
   task automatic check_offset();
      phase_t f;
      phase_t off;
      f = phase_t'($urandom) | phase_t'(1);
      off = phase_t'(3 << 20);
      apply_reset(f, off);
      collect_samples(n_offset, 0);
      compare_to_model(f, off, 3, "offset");
   endtask

   initial begin
      reset = 1'b1;
      freq = '0;
      offset = '0;
      sample_ready = 1'b0;
      void'($urandom(90)); // one seed for the whole run
      check_valid_timing();
      check_quadrants();
      check_random_freq();
      check_back_pressure();
      check_offset();
      total_fail = errors + UUT.u_assert.assert_failures;
      $display("checks %0d, errors %0d, assertion failures %0d",
               checks, errors, UUT.u_assert.assert_failures);
      if (total_fail == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

   // hard stop if the handshake never completes
   initial begin
      #(watchdog_ns);
      $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
      $display("Test failed");
      $finish;
   end

endmodule

//--- dds_top.f
+incdir+.
dds_num_pkg.sv
dds_table_pkg.sv
delay_line.sv
phase_accumulator.sv
quadrant_fold.sv
cos_table.sv
cosine_interp.sv
dds_top.sv
tb_clock_gen.sv
dds_assertions.sv
dds_tb.sv

//--- dds_top.sv
// freq and offset are treated as static settings; there is no input handshake
`timescale 1ns/1ns

module dds_top (
   input logic c,
   input logic reset,
   input dds_num_pkg::phase_t freq,
   input dds_num_pkg::phase_t offset,
   output dds_num_pkg::sample_t sample,
   output logic sample_valid,
   input logic sample_ready
);
   import dds_num_pkg::*;
   import dds_table_pkg::*;

   logic advance;           // common stall for every stage
   phase_t phase;
   logic phase_valid;
   table_addr_t addr;
   frac_t frac;
   logic sign;
   logic fold_valid;
   table_word_t word;

   phase_accumulator u_acc (
      .c(c), .reset(reset), .advance(advance),
      .freq(freq), .offset(offset),
      .phase(phase), .phase_valid(phase_valid)
   );

   quadrant_fold u_fold (
      .c(c), .reset(reset), .advance(advance),
      .phase(phase), .phase_valid(phase_valid),
      .addr(addr), .frac(frac), .sign(sign), .fold_valid(fold_valid)
   );

   cos_table u_table (
      .c(c), .advance(advance),
      .addr(addr), .word(word)
   );

   cosine_interp u_interp (
      .c(c), .reset(reset),
      .frac(frac), .sign(sign), .fold_valid(fold_valid), .word(word),
      .sample(sample), .sample_valid(sample_valid), .sample_ready(sample_ready),
      .advance(advance)
   );

endmodule

//--- delay_line.sv
// DEPTH must be 1 or more; payload_t must be a packed type so it can clear to zero
`timescale 1ns/1ns

module delay_line #(
   parameter type payload_t = logic,
   parameter int DEPTH = 1
) (
   input logic c,
   input logic reset,
   input logic advance, // shift enable, low while the consumer stalls
   input payload_t d,
   output payload_t q
);

   payload_t stage [DEPTH]; // stage[0] is nearest the input

   always_ff @(posedge c) begin
      if (reset) begin
         for (int i = 0; i < DEPTH; i++) begin
            stage[i] <= '0;
         end
      end else if (advance) begin
         stage[0] <= d;
         for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1]; // whole chain moves together
         end
      end
   end

   assign q = stage[DEPTH-1];

endmodule

//--- phase_accumulator.sv
// freq and offset are sampled every advance; changing them mid-stream bends the phase sequence
`timescale 1ns/1ns

module phase_accumulator (
   input logic c,
   input logic reset,
   input logic advance,
   input dds_num_pkg::phase_t freq,   // phase step per sample
   input dds_num_pkg::phase_t offset, // static phase offset
   output dds_num_pkg::phase_t phase,
   output logic phase_valid
);
   import dds_num_pkg::*;

   phase_t acc; // k*freq for the sample being issued

   // control state, starts at zero so sample 0 carries just the offset
   always_ff @(posedge c) begin
      if (reset) begin
         acc <= '0;
         phase_valid <= 1'b0;
      end else if (advance) begin
         acc <= acc + freq; // wraps mod 2^22
         phase_valid <= 1'b1; // first advance after reset
      end
   end

   // payload register, only meaningful once phase_valid is up
   always_ff @(posedge c) begin
      if (advance) begin
         phase <= acc + offset;
      end
   end

endmodule

//--- quadrant_fold.sv
// odd quadrants mirror by bit complement, which is one phase LSB off the exact mirror point
`timescale 1ns/1ns
`include "dds_cfg.svh"

module quadrant_fold (
   input logic c,
   input logic reset,
   input logic advance,
   input dds_num_pkg::phase_t phase,
   input logic phase_valid,
   output dds_table_pkg::table_addr_t addr,
   output dds_num_pkg::frac_t frac,
   output logic sign, // high for a negative result
   output logic fold_valid
);

   localparam int phase_w = `DDS_PHASE_W;
   localparam int frac_w = `DDS_FRAC_W;

   logic [1:0] quad;
   logic [phase_w-3:0] low; // position within the quadrant, after mirroring

   assign quad = phase[phase_w-1 -: 2];
   assign low = quad[0] ? ~phase[phase_w-3:0] : phase[phase_w-3:0]; // quadrants 1 and 3 mirror

   always_ff @(posedge c) begin
      if (advance) begin
         addr <= low[phase_w-3:frac_w];
         frac <= low[frac_w-1:0];
         sign <= quad[1] ^ quad[0]; // quadrants 1 and 2 are negative
      end
   end

   always_ff @(posedge c) begin
      if (reset) begin
         fold_valid <= 1'b0;
      end else if (advance) begin
         fold_valid <= phase_valid;
      end
   end

endmodule

//--- tb_clock_gen.sv
// free running clock from time 0, starts low; PERIOD_NS should be even
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int PERIOD_NS = 8
) (
   output logic c
);

   initial c = 1'b0;
   always #(PERIOD_NS / 2) c = ~c; // half period per toggle

endmodule
